// ==== sources.f ====
design/core_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv_core.sv
tests/clock_gen.sv
tests/rv_core_checker.sv
tests/tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := sources.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
BUILD      := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/tb_rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_rv_core;
  import core_pkg::*;

  localparam int prog_len = 128;

  logic            CLK;
  logic            RST;
  logic [xlen-1:0] fetch_adr;
  logic [xlen-1:0] fetch_dat;
  retire_t         retire;

  logic [31:0] prog_mem [0:prog_len-1];
  logic [31:0] ref_regs [0:31];
  retire_t     expected_q [$];
  integer      seed;
  int          ret_idx = 0;
  int          mismatches = 0;
  int          timeouts = 0;
  int          cycles = 0;
  int          cycle_limit;

  clock_gen clock_gen_inst (
    .CLK (CLK),
    .RST (RST)
  );

  rv_core uut (
    .CLK         (CLK),
    .RST         (RST),
    .fetch_adr_o (fetch_adr),
    .fetch_dat_i (fetch_dat),
    .retire_o    (retire)
  );

  bind rv_core rv_core_checker checker_inst (
    .CLK         (CLK),
    .RST         (RST),
    .fetch_adr_i (fetch_adr_o),
    .retire_i    (retire_o)
  );

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////

  // sel picks add sub sll slt xor srl or and
  function automatic logic [31:0] r_type_word(input logic [2:0] sel, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = (sel < 3'd2) ? 3'b000 : (sel < 3'd4) ? sel - 3'd1 : sel;
    f7 = (sel == 3'd1) ? 7'b0100000 : 7'b0000000;
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // addi slti xori ori andi
  function automatic logic [31:0] i_type_word(input logic [2:0] sel, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [11:0] imm);
    logic [2:0] k;
    logic [2:0] f3;
    k  = 3'(int'(sel) % 5);
    f3 = (k == 3'd0) ? 3'b000 : (k == 3'd4) ? 3'b111 : {k[1:0], 1'b0};
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] branch_word(input logic bne, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////
  // program and reference model
  ////////////////////////////////////////////////////////////

  task automatic generate_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          kind;
    int          off;
    for (int i = 0; i < prog_len - 1; i++) begin
      r    = $random(seed);
      kind = int'(r[3:0]);
      off  = 2 + int'(r[6:4]) % 5;
      // only x0..x7 so dependencies are dense
      rd   = {2'b00, r[9:7]};
      rs1  = {2'b00, r[12:10]};
      rs2  = {2'b00, r[15:13]};
      // jumps must land inside the program
      if (kind >= 12 && kind <= 14 && i + off > prog_len - 1) begin
        kind = 6;
      end
      case (kind)
        6, 7, 8, 9, 10: prog_mem[i] = i_type_word(r[18:16], rd, rs1, r[30:19]);
        11:             prog_mem[i] = {r[31:12], rd, 7'b0110111};
        12, 13:         prog_mem[i] = branch_word(r[16], rs1, rs2, 13'(off * 4));
        14:             prog_mem[i] = jal_word(rd, 21'(off * 4));
        default:        prog_mem[i] = r_type_word(r[18:16], rd, rs1, rs2);
      endcase
    end
    // self loop closes the program
    prog_mem[prog_len-1] = jal_word(5'd0, 21'd0);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction at ISA level
  function automatic retire_t reference_step(input logic [31:0] pc, input logic [31:0] insn,
                                             output logic [31:0] next_pc);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] val;
    logic        wr;
    rd      = insn[11:7];
    a       = ref_regs[insn[19:15]];
    b       = ref_regs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    next_pc = pc + 32'd4;
    val     = '0;
    wr      = 1'b1;
    case (insn[6:0])
      7'b0110011: val = alu_ref(insn[14:12], insn[30], a, b);
      7'b0010011: val = alu_ref(insn[14:12], 1'b0, a, imm_i);
      7'b0110111: val = {insn[31:12], 12'b0};
      7'b1101111: begin
        val     = pc + 32'd4;
        next_pc = pc + imm_j;
      end
      7'b1100011: begin
        wr = 1'b0;
        // funct3 bit 0 set means bne
        if ((a == b) != insn[12]) begin
          next_pc = pc + imm_b;
        end
      end
      default: wr = 1'b0;
    endcase
    if (!wr) begin
      rd = '0;
    end
    if (rd == '0) begin
      val = '0;
    end else begin
      ref_regs[rd] = val;
    end
    return '{valid: 1'b1, pc: pc, insn: insn, rd_addr: rd, rd_wdata: val};
  endfunction

  task automatic build_expected();
    logic [31:0] pc;
    logic [31:0] next_pc;
    retire_t     rec;
    pc = reset_pc;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    for (int n = 0; n < prog_len; n++) begin
      rec = reference_step(pc, prog_mem[pc[8:2]], next_pc);
      expected_q.push_back(rec);
      if (next_pc == pc) begin
        break;
      end
      pc = next_pc;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model and comparator
  ////////////////////////////////////////////////////////////

  // word for last cycle's address
  always @(posedge CLK) begin
    if (fetch_adr[31:9] == '0) begin
      fetch_dat <= prog_mem[fetch_adr[8:2]];
    end else begin
      fetch_dat <= '0;
    end
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  always @(negedge CLK) begin : compare_retire
    retire_t exp_rec;
    if (!RST && retire.valid) begin
      exp_rec = expected_q[ret_idx];
      check_field("retire_o.pc", retire.pc, exp_rec.pc);
      check_field("retire_o.insn", retire.insn, exp_rec.insn);
      check_field("retire_o.rd_addr", 32'(retire.rd_addr), 32'(exp_rec.rd_addr));
      check_field("retire_o.rd_wdata", retire.rd_wdata, exp_rec.rd_wdata);
      ret_idx++;
    end
  end

  initial begin
    fetch_dat = '0;
    seed      = 32'hbad4_3300;
    generate_program();
    build_expected();
    cycle_limit = 4 * expected_q.size() + 40;
    while (ret_idx < expected_q.size() && cycles < cycle_limit) begin
      @(posedge CLK);
      cycles++;
    end
    if (ret_idx < expected_q.size()) begin
      timeouts++;
      $display("timeout after %0d cycles with %0d of %0d instructions retired",
               cycles, ret_idx, expected_q.size());
    end
    $display("mismatches %0d, timeouts %0d, retired %0d of %0d",
             mismatches, timeouts, ret_idx, expected_q.size());
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/rv_core_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_checker (
  input logic                      CLK,
  input logic                      RST,
  input logic [core_pkg::xlen-1:0] fetch_adr_i,
  input core_pkg::retire_t         retire_i
);

  // quiet through reset and the first cycle after it
  valid_low_in_reset: assert property (
    @(posedge CLK) $past(RST) |-> !retire_i.valid
  ) else $error("retire_o.valid high while the core is in reset");

  fetch_word_aligned: assert property (
    @(posedge CLK) disable iff (RST) fetch_adr_i[1:0] == 2'b00
  ) else $error("fetch_adr_o is not word aligned");

  x0_writes_zero: assert property (
    @(posedge CLK) disable iff (RST)
      (retire_i.valid && retire_i.rd_addr == '0) |-> retire_i.rd_wdata == '0
  ) else $error("retirement to x0 carries nonzero write data");

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int period_ns    = 100;
  localparam int reset_cycles = 10;

  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  // release on a rising edge like every other input
  initial begin
    RST = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core (
  input  logic                       CLK,
  input  logic                       RST,
  output logic [core_pkg::xlen-1:0]  fetch_adr_o,
  input  logic [core_pkg::xlen-1:0]  fetch_dat_i,
  output core_pkg::retire_t          retire_o
);
  import core_pkg::*;

  // stage records
  if_id_t if_id;
  id_ex_t id_ex;

  // control flow change resolved in execute
  logic            redirect;
  logic [xlen-1:0] target;

  ////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////

  fetch_stage fetch_stage_inst (
    .CLK         (CLK),
    .RST         (RST),
    .redirect_i  (redirect),
    .target_i    (target),
    .fetch_adr_o (fetch_adr_o),
    .fetch_dat_i (fetch_dat_i),
    .if_id_o     (if_id)
  );

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // the retirement record doubles as the register write port
  decode_stage decode_stage_inst (
    .CLK     (CLK),
    .RST     (RST),
    .if_id_i (if_id),
    .flush_i (redirect),
    .wb_i    (retire_o),
    .id_ex_o (id_ex)
  );

  ////////////////////////////////////////////////////////////
  // execute and writeback
  ////////////////////////////////////////////////////////////

  execute_stage execute_stage_inst (
    .CLK        (CLK),
    .RST        (RST),
    .id_ex_i    (id_ex),
    .redirect_o (redirect),
    .target_o   (target),
    .retire_o   (retire_o)
  );

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
  input  logic                      CLK,
  input  logic                      RST,
  input  core_pkg::id_ex_t          id_ex_i,
  output logic                      redirect_o,
  output logic [core_pkg::xlen-1:0] target_o,
  output core_pkg::retire_t         retire_o
);
  import core_pkg::*;

  logic [xlen-1:0] src_a;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] result;
  logic            taken;

  ////////////////////////////////////////////////////////////
  // operand forwarding from the writeback register
  ////////////////////////////////////////////////////////////

  function automatic logic [xlen-1:0] forward(input retire_t wb,
                                              input logic [reg_addr_w-1:0] idx,
                                              input logic [xlen-1:0] data);
    if (wb.valid && (idx != '0) && (idx == wb.rd_addr)) begin
      return wb.rd_wdata;
    end
    return data;
  endfunction

  assign src_a   = forward(retire_o, id_ex_i.rs1_addr, id_ex_i.rs1_data);
  assign rs2_val = forward(retire_o, id_ex_i.rs2_addr, id_ex_i.rs2_data);
  assign src_b   = id_ex_i.ctrl.src_b_imm ? id_ex_i.imm : rs2_val;

  ////////////////////////////////////////////////////////////
  // alu and branch resolution
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      alu_add:    alu_res = src_a + src_b;
      alu_sub:    alu_res = src_a - src_b;
      alu_and:    alu_res = src_a & src_b;
      alu_or:     alu_res = src_a | src_b;
      alu_xor:    alu_res = src_a ^ src_b;
      alu_slt:    alu_res = xlen'($signed(src_a) < $signed(src_b));
      alu_sll:    alu_res = src_a << src_b[4:0];
      alu_srl:    alu_res = src_a >> src_b[4:0];
      alu_pass_b: alu_res = src_b;
      default:    alu_res = src_a + src_b;
    endcase
  end

  // bne flips the sense of the equality test
  assign taken = id_ex_i.ctrl.branch && ((src_a == rs2_val) ^ id_ex_i.ctrl.bne);

  assign redirect_o = id_ex_i.valid && (id_ex_i.ctrl.jal || taken);
  assign target_o   = id_ex_i.pc + id_ex_i.imm;

  // jal links the return address
  assign result = id_ex_i.ctrl.jal ? id_ex_i.pc + xlen'(4) : alu_res;

  // writeback register, also the retirement trace
  always_ff @(posedge CLK) begin
    if (RST) begin
      retire_o <= '0;
    end else begin
      retire_o <= '{
        valid:    id_ex_i.valid,
        pc:       id_ex_i.pc,
        insn:     id_ex_i.insn,
        rd_addr:  id_ex_i.rd_addr,
        rd_wdata: (id_ex_i.rd_addr != '0) ? result : '0
      };
    end
  end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
  input  logic              CLK,
  input  logic              RST,
  input  core_pkg::if_id_t  if_id_i,
  input  logic              flush_i,
  input  core_pkg::retire_t wb_i,
  output core_pkg::id_ex_t  id_ex_o
);
  import core_pkg::*;

  logic [2:0]            funct3;
  logic                  funct7b5;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       imm_b;
  logic [xlen-1:0]       imm_j;
  logic [xlen-1:0]       imm;
  ctrl_t                 ctrl;

  ////////////////////////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////////////////////////

  assign funct3   = if_id_i.insn[14:12];
  assign funct7b5 = if_id_i.insn[30];
  assign rs1_addr = if_id_i.insn[19:15];
  assign rs2_addr = if_id_i.insn[24:20];

  assign imm_i = {{20{if_id_i.insn[31]}}, if_id_i.insn[31:20]};
  assign imm_u = {if_id_i.insn[31:12], 12'b0};
  assign imm_b = {{19{if_id_i.insn[31]}}, if_id_i.insn[31], if_id_i.insn[7],
                  if_id_i.insn[30:25], if_id_i.insn[11:8], 1'b0};
  assign imm_j = {{11{if_id_i.insn[31]}}, if_id_i.insn[31], if_id_i.insn[19:12],
                  if_id_i.insn[20], if_id_i.insn[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  // anything not recognised stays a cleared ctrl_t, i.e. a nop
  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    case (if_id_i.insn[6:0])
      opc_op: begin
        ctrl.we = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7b5 ? alu_sub : alu_add;
          3'b001:  ctrl.alu_op = alu_sll;
          3'b010:  ctrl.alu_op = alu_slt;
          3'b100:  ctrl.alu_op = alu_xor;
          3'b101:  ctrl.alu_op = alu_srl;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.we = 1'b0;
        endcase
      end
      opc_op_imm: begin
        ctrl.we        = 1'b1;
        ctrl.src_b_imm = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = alu_add;
          3'b010:  ctrl.alu_op = alu_slt;
          3'b100:  ctrl.alu_op = alu_xor;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.we = 1'b0;
        endcase
      end
      opc_lui: begin
        ctrl.we        = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = alu_pass_b;
        imm            = imm_u;
      end
      opc_jal: begin
        ctrl.we  = 1'b1;
        ctrl.jal = 1'b1;
        imm      = imm_j;
      end
      opc_branch: begin
        // beq and bne only
        ctrl.branch = (funct3[2:1] == 2'b00);
        ctrl.bne    = funct3[0];
        imm         = imm_b;
      end
      default: ;
    endcase
  end

  // no write means rd x0
  assign rd_addr = ctrl.we ? if_id_i.insn[11:7] : '0;

  regfile regfile_inst (
    .CLK        (CLK),
    .RST        (RST),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_addr_i  (wb_i.rd_addr),
    .rd_data_i  (wb_i.rd_wdata),
    .rd_we_i    (wb_i.valid),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // decode/execute register
  always_ff @(posedge CLK) begin
    if (RST || flush_i) begin
      id_ex_o.valid <= 1'b0;
    end else begin
      id_ex_o <= '{
        valid:    if_id_i.valid,
        pc:       if_id_i.pc,
        insn:     if_id_i.insn,
        ctrl:     ctrl,
        rs1_addr: rs1_addr,
        rs2_addr: rs2_addr,
        rd_addr:  rd_addr,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm
      };
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module fetch_stage (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      redirect_i,
  input  logic [core_pkg::xlen-1:0] target_i,
  output logic [core_pkg::xlen-1:0] fetch_adr_o,
  input  logic [core_pkg::xlen-1:0] fetch_dat_i,
  output core_pkg::if_id_t          if_id_o
);
  import core_pkg::*;

  logic [xlen-1:0] pc_q;
  // address whose word arrives on fetch_dat_i this cycle
  logic [xlen-1:0] adr_q;
  logic            adr_valid_q;

  // a redirect reuses the current fetch slot for the target
  assign fetch_adr_o = redirect_i ? target_i : pc_q;

  always_ff @(posedge CLK) begin
    if (RST) begin
      pc_q        <= reset_pc;
      adr_valid_q <= 1'b0;
    end else begin
      pc_q        <= fetch_adr_o + xlen'(4);
      adr_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    adr_q <= fetch_adr_o;
  end

  // fetch/decode register, word captured as it arrives
  always_ff @(posedge CLK) begin
    if (RST || redirect_i) begin
      if_id_o.valid <= 1'b0;
    end else begin
      if_id_o <= '{
        valid: adr_valid_q,
        pc:    adr_q,
        insn:  fetch_dat_i
      };
    end
  end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

module regfile (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr_i,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr_i,
  input  logic [core_pkg::reg_addr_w-1:0] rd_addr_i,
  input  logic [core_pkg::xlen-1:0]       rd_data_i,
  input  logic                            rd_we_i,
  output logic [core_pkg::xlen-1:0]       rs1_data_o,
  output logic [core_pkg::xlen-1:0]       rs2_data_o
);
  import core_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs_q [1:31];
  logic            wr_en;

  assign wr_en = rd_we_i && (rd_addr_i != '0);

  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // write-through so decode sees this cycle's writeback
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && (addr == rd_addr_i)) begin
      return rd_data_i;
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

`default_nettype wire

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////
  // widths and reset address
  ////////////////////////////////////////////////////////////

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // major opcodes of the kept instruction set
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_jal    = 7'b1101111,
    opc_branch = 7'b1100011
  } opcode_e;

  // add is zero so a cleared ctrl_t is a harmless add
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_slt    = 4'd5,
    alu_sll    = 4'd6,
    alu_srl    = 4'd7,
    alu_pass_b = 4'd8
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // stage records
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e alu_op;
    logic    src_b_imm;
    logic    we;
    logic    jal;
    logic    branch;
    logic    bne;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] insn;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       insn;
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
  } id_ex_t;

  // one record per completed instruction
  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       insn;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rd_wdata;
  } retire_t;

endpackage

`default_nettype wire
